// File: project.f
+incdir+include
rtl/safe_domain_pkg.sv
rtl/pad_bus_if.sv
rtl/reset_sync.sv
rtl/slow_clk_div.sv
rtl/pad_control.sv
rtl/safe_domain.sv
testbench/tb_safe_domain.sv

// File: run_sim.sh
#!/bin/sh
# Build the safe domain testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_safe_domain -o sim_tb

# The log decides the result, so a crashed run must not stop the script here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log
then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi
echo "Simulation PASSED"

// File: include/safe_domain_tb_tasks.svh
// Directed tests of the always-on domain, included inside the testbench top module
`ifndef SAFE_DOMAIN_TB_TASKS_SVH
`define SAFE_DOMAIN_TB_TASKS_SVH

  // ********************************************************************
  // Reset and slow clock
  // ********************************************************************

  // Pads spread over all three sources with inputs high, so a leaky synchronizer shows
  task automatic reset_release();
    reset   = 1'b1;
    for (int k = 0; k < safe_domain_pkg::N_IO; k++)
    begin
      pad_mux[k] = safe_domain_pkg::NBIT_PADMUX'(k % 3);
    end
    io_in   = '1;
    for (int i = 0; i < RESET_CYCLES; i++)
    begin
      @(negedge ref_clk);
      compare("reset_o", domain_reset, 1'b1);
      // Synchronizer is cleared from the second edge on
      if (i > 0)
      begin
        check_sources('0);
      end
    end
    reset = 1'b0;
    // First edge only samples the release
    @(negedge ref_clk);
    compare("reset_o", domain_reset, 1'b1);
    check_sources('0);
    @(negedge ref_clk);
    compare("reset_o", domain_reset, 1'b0);
  endtask

  task automatic slow_clock_timing();
    int waited;
    int highs;
    // Fresh reset so the divider phase is known
    @(negedge ref_clk);
    reset = 1'b1;
    repeat (3) @(negedge ref_clk);
    reset = 1'b0;
    waited = 0;
    while (domain_reset !== 1'b0 && waited < 8)
    begin
      @(negedge ref_clk);
      waited++;
    end
    if (domain_reset !== 1'b0)
    begin
      errors++;
      $display("Domain reset never released after reset_i dropped");
      return;
    end
    compare("slow_clk_o", slow_clk, 1'b0);
    // Cycles from release to the first rise
    waited = 0;
    while (slow_clk !== 1'b1 && waited < 4 * safe_domain_pkg::SLOW_CLK_DIV)
    begin
      @(negedge ref_clk);
      waited++;
    end
    compare("cycles to first slow_clk_o rise", waited, safe_domain_pkg::SLOW_CLK_DIV / 2);
    // Index 0 is the first high cycle
    highs = 0;
    for (int i = 0; i < SLOW_PERIODS * safe_domain_pkg::SLOW_CLK_DIV; i++)
    begin
      compare("slow_clk_o", slow_clk, ((i / (safe_domain_pkg::SLOW_CLK_DIV / 2)) % 2) == 0);
      highs += int'(slow_clk);
      @(negedge ref_clk);
    end
    compare("slow_clk_o high cycles", highs, SLOW_PERIODS * safe_domain_pkg::SLOW_CLK_DIV / 2);
  endtask

  // ********************************************************************
  // Pad routing
  // ********************************************************************

  // Outputs are combinational, so look half a cycle after the drive
  task automatic output_mux();
    for (int v = 0; v < N_VECTORS; v++)
    begin
      @(negedge ref_clk);
      shuffle_inputs();
      @(posedge ref_clk);
      compare("io_out_o", io_out, route_out(pad_mux, perio_out, gpio_out, fpgaio_out));
      compare("io_oe_o", io_oe, route_out(pad_mux, perio_oe, gpio_oe, fpgaio_oe));
    end
  endtask

  task automatic cfg_passthrough();
    for (int v = 0; v < N_VECTORS; v++)
    begin
      @(negedge ref_clk);
      shuffle_inputs();
      @(posedge ref_clk);
      compare("pad_cfg_o", pad_cfg_out, gate_cfg(pad_mux, pad_cfg_in));
    end
  endtask

  // New value must not show after one edge and must show after two
  task automatic input_demux();
    logic [safe_domain_pkg::N_SRC_IN-1:0] prev_exp;
    logic [safe_domain_pkg::N_SRC_IN-1:0] cur_exp;
    prev_exp = demux_in(pad_mux, io_in);
    repeat (2) @(negedge ref_clk);
    for (int v = 0; v < N_VECTORS; v++)
    begin
      shuffle_inputs();
      cur_exp = demux_in(pad_mux, io_in);
      @(negedge ref_clk);
      check_sources(prev_exp);
      @(negedge ref_clk);
      check_sources(cur_exp);
      prev_exp = cur_exp;
    end
  endtask

`endif

// File: testbench/tb_safe_domain.sv
// Testbench top for the always-on domain, with clock, watchdog, reference model and test run
`timescale 1ns/100ps

module tb_safe_domain;

  // Clock period in ns and random seed
  localparam int CLK_PERIOD = 20;
  localparam int unsigned SEED = 32'h4e6a_53f8;

  // Test lengths
  localparam int RESET_CYCLES = 10;
  localparam int SLOW_PERIODS = 20;
  localparam int N_VECTORS = 40;

  // Cycles of all tests together, then a margin on top for the watchdog
  localparam int TEST_CYCLES = RESET_CYCLES + 2 + 12
    + (4 + SLOW_PERIODS) * safe_domain_pkg::SLOW_CLK_DIV + 4 * N_VECTORS + 2;
  localparam int TIMEOUT = (TEST_CYCLES + 200) * CLK_PERIOD;

  logic ref_clk;
  logic reset;
  logic domain_reset;
  logic slow_clk;
  logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADMUX-1:0] pad_mux;
  logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADCFG-1:0] pad_cfg_in;
  logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADCFG-1:0] pad_cfg_out;
  logic [safe_domain_pkg::N_IO-1:0] io_out;
  logic [safe_domain_pkg::N_IO-1:0] io_oe;
  logic [safe_domain_pkg::N_IO-1:0] io_in;
  logic [safe_domain_pkg::N_PERIO-1:0] perio_out, perio_oe, perio_in;
  logic [safe_domain_pkg::N_GPIO-1:0] gpio_out, gpio_oe, gpio_in;
  logic [safe_domain_pkg::N_FPGAIO-1:0] fpgaio_out, fpgaio_oe, fpgaio_in;
  int errors = 0;

  safe_domain dut (
    .ref_clk_i    (ref_clk),
    .reset_i      (reset),
    .reset_o      (domain_reset),
    .slow_clk_o   (slow_clk),
    .pad_mux_i    (pad_mux),
    .pad_cfg_i    (pad_cfg_in),
    .pad_cfg_o    (pad_cfg_out),
    .io_out_o     (io_out),
    .io_oe_o      (io_oe),
    .io_in_i      (io_in),
    .perio_out_i  (perio_out),
    .perio_oe_i   (perio_oe),
    .perio_in_o   (perio_in),
    .gpio_out_i   (gpio_out),
    .gpio_oe_i    (gpio_oe),
    .gpio_in_o    (gpio_in),
    .fpgaio_out_i (fpgaio_out),
    .fpgaio_oe_i  (fpgaio_oe),
    .fpgaio_in_o  (fpgaio_in)
  );

  initial
  begin
    ref_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ref_clk = ~ref_clk;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT);
    $display("Timeout: tests still running after %0d ns", TIMEOUT);
    $display("sim failed");
    $finish;
  end

  task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // ********************************************************************
  // Reference model
  // ********************************************************************

  // Pad k follows line k mod width of the source its code names
  function automatic logic [safe_domain_pkg::N_IO-1:0] route_out(
    input logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADMUX-1:0] mux,
    input logic [safe_domain_pkg::N_PERIO-1:0]  p,
    input logic [safe_domain_pkg::N_GPIO-1:0]   g,
    input logic [safe_domain_pkg::N_FPGAIO-1:0] f
  );
    logic [safe_domain_pkg::N_IO-1:0] r;
    for (int k = 0; k < safe_domain_pkg::N_IO; k++)
    begin
      case (mux[k])
        safe_domain_pkg::PAD_PERIO:  r[k] = p[k % safe_domain_pkg::N_PERIO];
        safe_domain_pkg::PAD_GPIO:   r[k] = g[k % safe_domain_pkg::N_GPIO];
        safe_domain_pkg::PAD_FPGAIO: r[k] = f[k % safe_domain_pkg::N_FPGAIO];
        default:                     r[k] = 1'b0;
      endcase
    end
    return r;
  endfunction

  // Parked pads carry no setting
  function automatic logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADCFG-1:0] gate_cfg(
    input logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADMUX-1:0] mux,
    input logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADCFG-1:0] cfg
  );
    logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADCFG-1:0] r;
    r = cfg;
    for (int k = 0; k < safe_domain_pkg::N_IO; k++)
    begin
      if (mux[k] == safe_domain_pkg::PAD_OFF)
      begin
        r[k] = '0;
      end
    end
    return r;
  endfunction

  // Lowest pad selecting the source on this line wins, no pad gives 0
  function automatic logic first_pad_input(
    input logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADMUX-1:0] mux,
    input logic [safe_domain_pkg::N_IO-1:0] io,
    input int sel,
    input int width,
    input int line
  );
    for (int k = 0; k < safe_domain_pkg::N_IO; k++)
    begin
      if (mux[k] == sel && (k % width) == line)
      begin
        return io[k];
      end
    end
    return 1'b0;
  endfunction

  // All source inputs packed as {fpgaio, gpio, perio}
  function automatic logic [safe_domain_pkg::N_SRC_IN-1:0] demux_in(
    input logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADMUX-1:0] mux,
    input logic [safe_domain_pkg::N_IO-1:0] io
  );
    logic [safe_domain_pkg::N_PERIO-1:0]  p;
    logic [safe_domain_pkg::N_GPIO-1:0]   g;
    logic [safe_domain_pkg::N_FPGAIO-1:0] f;
    for (int j = 0; j < safe_domain_pkg::N_PERIO; j++)
    begin
      p[j] = first_pad_input(mux, io, safe_domain_pkg::PAD_PERIO, safe_domain_pkg::N_PERIO, j);
    end
    for (int j = 0; j < safe_domain_pkg::N_GPIO; j++)
    begin
      g[j] = first_pad_input(mux, io, safe_domain_pkg::PAD_GPIO, safe_domain_pkg::N_GPIO, j);
    end
    for (int j = 0; j < safe_domain_pkg::N_FPGAIO; j++)
    begin
      f[j] = first_pad_input(mux, io, safe_domain_pkg::PAD_FPGAIO, safe_domain_pkg::N_FPGAIO, j);
    end
    return {f, g, p};
  endfunction

  // ********************************************************************
  // Stimulus helpers
  // ********************************************************************

  task automatic check_sources(input logic [safe_domain_pkg::N_SRC_IN-1:0] exp);
    compare("perio_in_o", perio_in, exp[safe_domain_pkg::N_PERIO-1:0]);
    compare("gpio_in_o", gpio_in, exp[safe_domain_pkg::N_PERIO +: safe_domain_pkg::N_GPIO]);
    compare("fpgaio_in_o", fpgaio_in,
            exp[safe_domain_pkg::N_PERIO + safe_domain_pkg::N_GPIO +: safe_domain_pkg::N_FPGAIO]);
  endtask

  // Called right after a falling edge
  task automatic shuffle_inputs();
    pad_mux    = $urandom;
    pad_cfg_in = {$urandom, $urandom, $urandom};
    io_in      = $urandom;
    perio_out  = $urandom;
    perio_oe   = $urandom;
    gpio_out   = $urandom;
    gpio_oe    = $urandom;
    fpgaio_out = $urandom;
    fpgaio_oe  = $urandom;
  endtask

  `include "safe_domain_tb_tasks.svh"

  initial
  begin
    void'($urandom(SEED));
    reset      = 1'b1;
    pad_mux    = '0;
    pad_cfg_in = '0;
    io_in      = '0;
    perio_out  = '0;
    perio_oe   = '0;
    gpio_out   = '0;
    gpio_oe    = '0;
    fpgaio_out = '0;
    fpgaio_oe  = '0;
    reset_release();
    slow_clock_timing();
    output_mux();
    cfg_passthrough();
    input_demux();
    $display("Checks done, errors: %0d", errors);
    if (errors == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: rtl/safe_domain.sv
// Always-on domain top: reset synchronizer, slow clock divider and pad router on plain ports
`timescale 1ns/100ps

module safe_domain (
  // Clock and reset
  input  logic                                  ref_clk_i,
  input  logic                                  reset_i,
  output logic                                  reset_o,
  output logic                                  slow_clk_o,

  // Pad control fields
  input  logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADMUX-1:0] pad_mux_i,
  input  logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADCFG-1:0] pad_cfg_i,
  output logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADCFG-1:0] pad_cfg_o,

  // Pads
  output logic [safe_domain_pkg::N_IO-1:0]      io_out_o,
  output logic [safe_domain_pkg::N_IO-1:0]      io_oe_o,
  input  logic [safe_domain_pkg::N_IO-1:0]      io_in_i,

  // Peripheral IOs
  input  logic [safe_domain_pkg::N_PERIO-1:0]   perio_out_i,
  input  logic [safe_domain_pkg::N_PERIO-1:0]   perio_oe_i,
  output logic [safe_domain_pkg::N_PERIO-1:0]   perio_in_o,

  // GPIOs
  input  logic [safe_domain_pkg::N_GPIO-1:0]    gpio_out_i,
  input  logic [safe_domain_pkg::N_GPIO-1:0]    gpio_oe_i,
  output logic [safe_domain_pkg::N_GPIO-1:0]    gpio_in_o,

  // FPGA IOs
  input  logic [safe_domain_pkg::N_FPGAIO-1:0]  fpgaio_out_i,
  input  logic [safe_domain_pkg::N_FPGAIO-1:0]  fpgaio_oe_i,
  output logic [safe_domain_pkg::N_FPGAIO-1:0]  fpgaio_in_o
);

  // Synchronized domain reset
  logic domain_reset;

  // ********************************************************************
  // Reset and slow clock
  // ********************************************************************

  reset_sync u_reset_sync (
    .ref_clk_i (ref_clk_i),
    .reset_i   (reset_i),
    .reset_o   (domain_reset)
  );

  // Divider runs from the synchronized reset
  slow_clk_div u_slow_clk_div (
    .ref_clk_i  (ref_clk_i),
    .reset_i    (domain_reset),
    .slow_clk_o (slow_clk_o)
  );

  assign reset_o = domain_reset;

  // ********************************************************************
  // Pad routing
  // ********************************************************************

  pad_bus_if pads ();

  // Raw pad codes into enum form
  always_comb
  begin
    for (int k = 0; k < safe_domain_pkg::N_IO; k++)
    begin
      pads.pad_mux[k] = safe_domain_pkg::pad_sel_e'(pad_mux_i[k]);
    end
  end

  // Chip-side fields from and to the top ports
  assign pads.io_in      = io_in_i;
  assign pads.pad_cfg_in = pad_cfg_i;
  assign io_out_o        = pads.io_out;
  assign io_oe_o         = pads.io_oe;
  assign pad_cfg_o       = pads.pad_cfg_out;

  pad_control u_pad_control (
    .ref_clk_i    (ref_clk_i),
    .reset_i      (domain_reset),
    .pads         (pads.router),
    .perio_out_i  (perio_out_i),
    .perio_oe_i   (perio_oe_i),
    .perio_in_o   (perio_in_o),
    .gpio_out_i   (gpio_out_i),
    .gpio_oe_i    (gpio_oe_i),
    .gpio_in_o    (gpio_in_o),
    .fpgaio_out_i (fpgaio_out_i),
    .fpgaio_oe_i  (fpgaio_oe_i),
    .fpgaio_in_o  (fpgaio_in_o)
  );

endmodule

// File: rtl/pad_control.sv
// Pad router: per-pad source mux, config gating and synchronized input demux to the sources
`timescale 1ns/100ps

module pad_control (
  input  logic                                  ref_clk_i,
  input  logic                                  reset_i,

  // Pad side
  pad_bus_if.router                             pads,

  // Peripheral IOs
  input  logic [safe_domain_pkg::N_PERIO-1:0]   perio_out_i,
  input  logic [safe_domain_pkg::N_PERIO-1:0]   perio_oe_i,
  output logic [safe_domain_pkg::N_PERIO-1:0]   perio_in_o,

  // GPIOs
  input  logic [safe_domain_pkg::N_GPIO-1:0]    gpio_out_i,
  input  logic [safe_domain_pkg::N_GPIO-1:0]    gpio_oe_i,
  output logic [safe_domain_pkg::N_GPIO-1:0]    gpio_in_o,

  // FPGA IOs
  input  logic [safe_domain_pkg::N_FPGAIO-1:0]  fpgaio_out_i,
  input  logic [safe_domain_pkg::N_FPGAIO-1:0]  fpgaio_oe_i,
  output logic [safe_domain_pkg::N_FPGAIO-1:0]  fpgaio_in_o
);

  // Demuxed pad inputs per source, before synchronization
  logic [safe_domain_pkg::N_PERIO-1:0]  perio_in_d;
  logic [safe_domain_pkg::N_GPIO-1:0]   gpio_in_d;
  logic [safe_domain_pkg::N_FPGAIO-1:0] fpgaio_in_d;

  // Synchronizer chain over all source lines
  logic [safe_domain_pkg::IN_SYNC_STAGES-1:0][safe_domain_pkg::N_SRC_IN-1:0] sync_q;

  // ********************************************************************
  // Output direction
  // ********************************************************************

  // Pad k drives from line k mod width of its selected source
  always_comb
  begin
    for (int k = 0; k < safe_domain_pkg::N_IO; k++)
    begin
      unique case (pads.pad_mux[k])
        safe_domain_pkg::PAD_PERIO:
        begin
          pads.io_out[k] = perio_out_i[k % safe_domain_pkg::N_PERIO];
          pads.io_oe[k]  = perio_oe_i[k % safe_domain_pkg::N_PERIO];
        end
        safe_domain_pkg::PAD_GPIO:
        begin
          pads.io_out[k] = gpio_out_i[k % safe_domain_pkg::N_GPIO];
          pads.io_oe[k]  = gpio_oe_i[k % safe_domain_pkg::N_GPIO];
        end
        safe_domain_pkg::PAD_FPGAIO:
        begin
          pads.io_out[k] = fpgaio_out_i[k % safe_domain_pkg::N_FPGAIO];
          pads.io_oe[k]  = fpgaio_oe_i[k % safe_domain_pkg::N_FPGAIO];
        end
        default:
        begin
          // Parked pad, driver off
          pads.io_out[k] = 1'b0;
          pads.io_oe[k]  = 1'b0;
        end
      endcase

      // Config passes through unless the pad is parked
      if (pads.pad_mux[k] == safe_domain_pkg::PAD_OFF)
      begin
        pads.pad_cfg_out[k] = '0;
      end
      else
      begin
        pads.pad_cfg_out[k] = pads.pad_cfg_in[k];
      end
    end
  end

  // ********************************************************************
  // Input direction
  // ********************************************************************

  // Walk pads from the top down so the lowest selecting pad wins
  // Lines with no selecting pad stay 0
  always_comb
  begin
    perio_in_d  = '0;
    gpio_in_d   = '0;
    fpgaio_in_d = '0;
    for (int k = safe_domain_pkg::N_IO - 1; k >= 0; k--)
    begin
      if (pads.pad_mux[k] == safe_domain_pkg::PAD_PERIO)
      begin
        perio_in_d[k % safe_domain_pkg::N_PERIO] = pads.io_in[k];
      end
      if (pads.pad_mux[k] == safe_domain_pkg::PAD_GPIO)
      begin
        gpio_in_d[k % safe_domain_pkg::N_GPIO] = pads.io_in[k];
      end
      if (pads.pad_mux[k] == safe_domain_pkg::PAD_FPGAIO)
      begin
        fpgaio_in_d[k % safe_domain_pkg::N_FPGAIO] = pads.io_in[k];
      end
    end
  end

  // Pads are asynchronous, so flop every line IN_SYNC_STAGES times
  // Cleared under reset so sources read 0
  always_ff @(posedge ref_clk_i)
  begin
    if (reset_i)
    begin
      sync_q <= '0;
    end
    else
    begin
      sync_q[0] <= {fpgaio_in_d, gpio_in_d, perio_in_d};
      for (int s = 1; s < safe_domain_pkg::IN_SYNC_STAGES; s++)
      begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  // Last stage feeds the sources
  assign {fpgaio_in_o, gpio_in_o, perio_in_o} = sync_q[safe_domain_pkg::IN_SYNC_STAGES-1];

  // ********************************************************************
  // Checks
  // ********************************************************************

  // A parked pad never drives and never carries a setting
  for (genvar k = 0; k < safe_domain_pkg::N_IO; k++)
  begin : g_off_check
    a_pad_off_quiet : assert property (
      @(posedge ref_clk_i)
      (pads.pad_mux[k] == safe_domain_pkg::PAD_OFF) |->
        (!pads.io_oe[k] && (pads.pad_cfg_out[k] == '0))
    );
  end

endmodule

// File: rtl/slow_clk_div.sv
// Counter-based divider producing the 50% duty slow clock from the reference clock
`timescale 1ns/100ps

module slow_clk_div (
  input  logic ref_clk_i,
  input  logic reset_i,
  output logic slow_clk_o
);

  // ********************************************************************
  // Phase counter and clock register
  // ********************************************************************

  // Last count of a phase
  localparam logic [safe_domain_pkg::SLOW_CNT_W-1:0] LAST_CNT =
    safe_domain_pkg::SLOW_CNT_W'(safe_domain_pkg::SLOW_HALF - 1);

  // Cycles spent in the current phase
  logic [safe_domain_pkg::SLOW_CNT_W-1:0] phase_cnt_q;

  // Registered output, no glitches
  logic slow_clk_q;

  // Low under reset, toggle at the end of each phase
  always_ff @(posedge ref_clk_i)
  begin
    if (reset_i)
    begin
      phase_cnt_q <= '0;
      slow_clk_q  <= 1'b0;
    end
    else if (phase_cnt_q == LAST_CNT)
    begin
      phase_cnt_q <= '0;
      slow_clk_q  <= ~slow_clk_q;
    end
    else
    begin
      phase_cnt_q <= phase_cnt_q + 1'b1;
    end
  end

  assign slow_clk_o = slow_clk_q;

  // ********************************************************************
  // Checks
  // ********************************************************************

  // No edge closer than SLOW_HALF cycles to the previous one
  for (genvar d = 1; d < safe_domain_pkg::SLOW_HALF; d++)
  begin : g_min_phase
    a_min_phase : assert property (
      @(posedge ref_clk_i) disable iff (reset_i)
      $changed(slow_clk_o) |-> ($past(slow_clk_o, d) == $past(slow_clk_o, d + 1))
    );
  end

endmodule

// File: rtl/reset_sync.sv
// Two-flop reset synchronizer that turns the board reset into the always-on domain reset
`timescale 1ns/100ps

module reset_sync (
  input  logic ref_clk_i,
  input  logic reset_i,
  output logic reset_o
);

  // ********************************************************************
  // Reset chain
  // ********************************************************************

  // Stage 0 samples release, stage 1 drives the domain
  logic [1:0] chain_q;

  // Set on reset, shift zeros in once reset_i drops
  always_ff @(posedge ref_clk_i)
  begin
    if (reset_i)
    begin
      chain_q <= 2'b11;
    end
    else
    begin
      chain_q <= {chain_q[0], 1'b0};
    end
  end

  // Assert is seen at the next edge
  // Release takes two edges
  assign reset_o = chain_q[1];

  // ********************************************************************
  // Checks
  // ********************************************************************

  // Board reset always reaches the domain one edge later
  a_reset_assert : assert property (
    @(posedge ref_clk_i) reset_i |=> reset_o
  );

  // Domain reset stays up for a cycle after the board reset drops
  a_reset_hold : assert property (
    @(posedge ref_clk_i) (reset_i ##1 !reset_i) |-> reset_o
  );

endmodule

// File: rtl/pad_bus_if.sv
// Pad-side bundle between the domain top and the pad router, with one view per side
`timescale 1ns/100ps

interface pad_bus_if;

  // ********************************************************************
  // Pad signals
  // ********************************************************************

  // Pad output value and output enable
  logic [safe_domain_pkg::N_IO-1:0] io_out;
  logic [safe_domain_pkg::N_IO-1:0] io_oe;

  // Raw pad input, asynchronous to ref clock
  logic [safe_domain_pkg::N_IO-1:0] io_in;

  // Per-pad mux code
  safe_domain_pkg::pad_sel_e pad_mux [safe_domain_pkg::N_IO];

  // Per-pad configuration, requested and delivered
  logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADCFG-1:0] pad_cfg_in;
  logic [safe_domain_pkg::N_IO-1:0][safe_domain_pkg::NBIT_PADCFG-1:0] pad_cfg_out;

  // Router side drives the pads
  modport router (
    output io_out,
    output io_oe,
    output pad_cfg_out,
    input  io_in,
    input  pad_mux,
    input  pad_cfg_in
  );

  // Chip side mirrors the router
  modport chip (
    input  io_out,
    input  io_oe,
    input  pad_cfg_out,
    output io_in,
    output pad_mux,
    output pad_cfg_in
  );

endinterface

// File: rtl/safe_domain_pkg.sv
// Shared constants and types of the always-on domain, referenced by scoped name from each file
package safe_domain_pkg;

  // ********************************************************************
  // Pad and source counts
  // ********************************************************************

  // Chip pads
  localparam int unsigned N_IO = 16;

  // Peripheral IO lines
  localparam int unsigned N_PERIO = 8;

  // GPIO lines
  localparam int unsigned N_GPIO = 8;

  // FPGA IO lines
  localparam int unsigned N_FPGAIO = 4;

  // All source input lines, packed as {fpgaio, gpio, perio}
  localparam int unsigned N_SRC_IN = N_PERIO + N_GPIO + N_FPGAIO;

  // ********************************************************************
  // Pad field widths
  // ********************************************************************

  // Mux code per pad
  localparam int unsigned NBIT_PADMUX = 2;

  // Opaque pad setting (drive, pull and so on)
  localparam int unsigned NBIT_PADCFG = 6;

  // ********************************************************************
  // Clocking and synchronization
  // ********************************************************************

  // Reference to slow clock ratio, must be even
  localparam int unsigned SLOW_CLK_DIV = 4;

  // Reference cycles per slow clock phase
  localparam int unsigned SLOW_HALF = SLOW_CLK_DIV / 2;

  // Phase counter width, at least one bit
  localparam int unsigned SLOW_CNT_W = (SLOW_HALF > 1) ? $clog2(SLOW_HALF) : 1;

  // Flops in the pad input synchronizer
  localparam int unsigned IN_SYNC_STAGES = 2;

  // ********************************************************************
  // Pad mux codes
  // ********************************************************************

  // Source a pad is routed to; PAD_OFF parks the pad
  typedef enum logic [NBIT_PADMUX-1:0] {
    PAD_PERIO  = NBIT_PADMUX'(0),
    PAD_GPIO   = NBIT_PADMUX'(1),
    PAD_FPGAIO = NBIT_PADMUX'(2),
    PAD_OFF    = NBIT_PADMUX'(3)
  } pad_sel_e;

endpackage
